/* bench/rc522CardModel.sv */
`timescale 1ns/10ps
`default_nettype none

module rc522CardModel import rfidPkg::*; (
    input  logic    clk,
    input  logic    chipRst,                    // NRSTPD from the DUT
    input  logic    sclk,
    input  logic    mosi,
    input  logic    csN,
    output logic    miso,                       // changes on the falling clk edge
    input  byteT    txCtrlInit,                 // TxControlReg after chip reset
    input  byteT    missCount,                  // polls that see no card
    input  byteT    fifoLevel,
    input  uidT     cardUid,
    input  byteT    cardBcc,
    output logic    frameDone,                  // one clock, a frame just ended
    output spiWordT frameWord                   // address byte then mosi data byte
);

    logic    csPrev = 1'b1;
    logic    sclkPrev = 1'b0;
    int      bitCnt = 0;
    int      irqReads = 0;                      // ComIrqReg reads since chip reset
    int      fifoIdx = 0;
    spiWordT rxWord = '0;
    byteT    txByte = '0;

    initial miso = 1'b0;
    initial frameDone = 1'b0;
    initial frameWord = '0;

    function automatic byteT fifoByte(input int idx);
        case (idx)
            0: return cardUid[31:24];           // card sends uid0 first
            1: return cardUid[23:16];
            2: return cardUid[15:8];
            3: return cardUid[7:0];
            4: return cardBcc;
            default: return 8'h00;              // fifo empty
        endcase
    endfunction

    // sclk and csN are sampled mid-cycle, edges seen half a clock late
    always @(negedge clk) begin
        frameDone = 1'b0;
        if (!chipRst) begin
            irqReads = 0;
            fifoIdx  = 0;
        end
        if (!csN && csPrev) begin
            bitCnt = 0;
        end
        if (!csN && sclk && !sclkPrev) begin
            rxWord = {rxWord[14:0], mosi};      // msb first
            bitCnt++;
        end
        if (!csN && !sclk && sclkPrev && bitCnt >= 8 && bitCnt < 16) begin
            if (bitCnt == 8) begin
                txByte = 8'h00;
                if (rxWord[7]) begin            // read frame, decode the address
                    case (rxWord[7:0] & ~ReadFlag)
                        TxControlReg: txByte = txCtrlInit;
                        FIFOLevelReg: txByte = fifoLevel;
                        ComIrqReg: begin
                            txByte = (irqReads < int'(missCount)) ? 8'h00 : byteT'(1 << RxIrqBit);
                            irqReads++;
                        end
                        FIFODataReg: begin
                            txByte = fifoByte(fifoIdx);
                            fifoIdx++;
                        end
                        default: txByte = 8'h00;
                    endcase
                end
            end else begin
                txByte = {txByte[6:0], 1'b0};
            end
            miso = txByte[7];
        end
        if (csN && !csPrev) begin
            frameDone = 1'b1;
            frameWord = rxWord;
            miso      = 1'b0;
            if (rxWord == {FIFOLevelReg, 8'h80}) begin
                fifoIdx = 0;                    // FlushBuffer
            end
        end
        csPrev   = csN;
        sclkPrev = sclk;
    end

endmodule

`default_nettype wire

/* bench/rc522Reader_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rc522Reader_tb import rfidPkg::*; ();

    localparam int Cols      = 11;              // values per stim row
    localparam int WaitLimit = 600000;          // clock limit per wait covers the led hold

    logic    clk;
    logic    rst_n;
    logic    miso;
    logic    sclk;
    logic    mosi;
    logic    csN;
    logic    chipRst;
    uidT     uid;
    logic    cardOk;
    ledT     rgb1;
    ledT     rgb2;
    byteT    txCtrlInit;
    byteT    missCount;
    byteT    fifoLevel;
    uidT     cardUid;
    byteT    cardBcc;
    logic    frameDone;
    spiWordT frameWord;

    byteT    stim [0:255];
    spiWordT frameQ [$];                        // every frame the model saw
    int      readIdx;
    int      okPulses;
    logic    okPrev;
    ledT     litRgb1;                           // last lit colour since reset
    ledT     litRgb2;

    rc522Reader #(
        .stepBits(10)                           // step longer than one spi frame
    ) rc522Reader_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .miso   (miso),
        .sclk   (sclk),
        .mosi   (mosi),
        .csN    (csN),
        .chipRst(chipRst),
        .uid    (uid),
        .cardOk (cardOk),
        .rgb1   (rgb1),
        .rgb2   (rgb2)
    );

    rc522CardModel chip (
        .clk       (clk),
        .chipRst   (chipRst),
        .sclk      (sclk),
        .mosi      (mosi),
        .csN       (csN),
        .miso      (miso),
        .txCtrlInit(txCtrlInit),
        .missCount (missCount),
        .fifoLevel (fifoLevel),
        .cardUid   (cardUid),
        .cardBcc   (cardBcc),
        .frameDone (frameDone),
        .frameWord (frameWord)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            okPulses <= 0;
            okPrev   <= 1'b0;
            litRgb1  <= LedOff;
            litRgb2  <= LedOff;
        end else begin
            okPrev <= cardOk;
            if (cardOk && !okPrev) begin
                okPulses <= okPulses + 1;
            end
            if (rgb1 != LedOff) begin
                litRgb1 <= rgb1;
            end
            if (rgb2 != LedOff) begin
                litRgb2 <= rgb2;
            end
        end
        if (frameDone) begin
            frameQ.push_back(frameWord);
        end
    end

    task automatic compareVal(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("gave up waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic waitChipRst(input logic level);
        int n;
        n = 0;
        while (chipRst !== level) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) begin
                timeoutFail("the chip reset pin");
            end
        end
    endtask

    task automatic frameIs(input string what, input spiWordT exp);
        int n;
        n = 0;
        while (frameQ.size() <= readIdx) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) begin
                timeoutFail("an SPI frame");
            end
        end
        compareVal(what, 32'(frameQ[readIdx]), 32'(exp));
        readIdx++;
    endtask

    task automatic initWrites(input byteT txc);
        frameIs("TxModeReg write", {TxModeReg, 8'h00});
        frameIs("RxModeReg write", {RxModeReg, 8'h00});
        frameIs("ModWidthReg write", {ModWidthReg, 8'h26});
        frameIs("TModeReg write", {TModeReg, 8'h80});
        frameIs("TPrescalerReg write", {TPrescalerReg, 8'hA9});
        frameIs("TReloadRegH write", {TReloadRegH, 8'h03});
        frameIs("TReloadRegL write", {TReloadRegL, 8'hE8});
        frameIs("TxASKReg write", {TxASKReg, 8'h40});
        frameIs("ModeReg write", {ModeReg, 8'h3D});
        frameIs("TxControlReg read", {TxControlReg | ReadFlag, 8'h00});
        frameIs("TxControlReg write", {TxControlReg, txc | 8'h03}); // antenna drivers on
    endtask

    task automatic reqaWrites();
        frameIs("REQA idle", {CommandReg, PcdIdle});
        frameIs("REQA irq clear", {ComIrqReg, 8'h7F});
        frameIs("REQA flush", {FIFOLevelReg, 8'h80});
        frameIs("REQA fifo byte", {FIFODataReg, PiccReqa});
        frameIs("REQA framing", {BitFramingReg, 8'h07});
        frameIs("REQA transceive", {CommandReg, PcdTransceive});
        frameIs("REQA start send", {BitFramingReg, 8'h87});
    endtask

    task automatic selectReads();
        frameIs("SELECT flush", {FIFOLevelReg, 8'h80});
        frameIs("SELECT cmd byte", {FIFODataReg, PiccSelCl1});
        frameIs("SELECT nvb byte", {FIFODataReg, 8'h20});
        frameIs("SELECT framing", {BitFramingReg, 8'h00});
        frameIs("SELECT transceive", {CommandReg, PcdTransceive});
        frameIs("SELECT start send", {BitFramingReg, 8'h80});
        frameIs("FIFOLevelReg read", {FIFOLevelReg | ReadFlag, 8'h00});
        repeat (5) frameIs("FIFODataReg read", {FIFODataReg | ReadFlag, 8'h00}); // uid bytes then bcc
    endtask

    initial begin
        logic [7:0] base;
        int         misses;
        int         polls;
        logic       expOk;
        rst_n      = 1'b0;
        txCtrlInit = '0;
        missCount  = '0;
        fifoLevel  = '0;
        cardUid    = '0;
        cardBcc    = '0;
        readIdx    = 0;
        $readmemh("bench/rc522Stim.txt", stim);
        base = 8'd1;
        repeat (stim[0]) begin
            @(negedge clk);
            rst_n      = 1'b0;                  // fresh power-up per card
            txCtrlInit = stim[base];
            missCount  = stim[base + 8'd1];
            fifoLevel  = stim[base + 8'd2];
            cardUid    = {stim[base + 8'd3], stim[base + 8'd4],
                          stim[base + 8'd5], stim[base + 8'd6]};
            cardBcc    = stim[base + 8'd7];
            // stim columns must agree with the frame and led rules
            expOk = (fifoLevel == 8'd5) && (cardBcc == (stim[base + 8'd3] ^ stim[base + 8'd4]
                ^ stim[base + 8'd5] ^ stim[base + 8'd6]));
            compareVal("stim cardOk column", 32'(stim[base + 8'd8]), 32'(expOk));
            compareVal("stim rgb1 column", 32'(stim[base + 8'd9]),
                (cardUid == UidKnownGood) ? 32'(LedWhite) : 32'(LedOff));
            compareVal("stim rgb2 column", 32'(stim[base + 8'd10]),
                (cardUid == UidKnownBad) ? 32'(LedWhite) : 32'(LedOff));
            repeat (2) @(negedge clk);
            readIdx = frameQ.size();
            rst_n   = 1'b1;

            waitChipRst(1'b0);
            waitChipRst(1'b1);
            compareVal("csN after chip reset", 32'(csN), 32'h1);
            compareVal("frames before chip reset", frameQ.size() - readIdx, 32'h0);
            initWrites(txCtrlInit);

            misses = int'(missCount);
            polls  = 0;
            reqaWrites();
            for (int k = 0; k <= misses; k++) begin
                if (polls == PollRetries) begin
                    reqaWrites();               // sequencer gave up and sent a new request
                    polls = 0;
                end
                frameIs("ComIrqReg poll", {ComIrqReg | ReadFlag, 8'h00});
                polls++;
            end

            selectReads();
            compareVal("uid", uid, cardUid);
            frameIs("next REQA idle", {CommandReg, PcdIdle}); // presentation over
            compareVal("cardOk pulses", 32'(okPulses), 32'(expOk));
            compareVal("cardOk before REQA", 32'(cardOk), 32'h0);
            compareVal("rgb1 while shown", 32'(litRgb1), 32'(stim[base + 8'd9]));
            compareVal("rgb2 while shown", 32'(litRgb2), 32'(stim[base + 8'd10]));
            compareVal("rgb1 before REQA", 32'(rgb1), 32'(LedOff));
            compareVal("rgb2 before REQA", 32'(rgb2), 32'(LedOff));
            base = base + 8'(Cols);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rc522Stim.txt */
// first value: number of card rows
// row: txCtrl misses level uid0 uid1 uid2 uid3 bcc cardOk rgb1 rgb2
06
80 00 05 23 59 A6 29 F5 01 07 00
84 02 05 F3 F3 A4 14 B0 01 00 07
00 07 05 12 34 56 78 08 01 00 00
83 01 05 23 59 A6 29 F4 00 07 00
40 00 04 F3 F3 A4 14 B0 00 00 07
81 05 05 DE AD BE EF 22 01 00 00

/* hw/cardCheck.sv */
`timescale 1ns/10ps
`default_nettype none

module cardCheck import rfidPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  byteT       spiRxByte,
    input  logic       capLevel,
    input  logic       capUid,
    input  logic [1:0] uidByteSel,              // 0 is the first byte off the card
    input  logic       capBcc,
    input  logic       checkFrame,
    input  logic       showLed,
    input  logic       clearLed,
    output uidT        uid,
    output logic       cardOk,
    output ledT        rgb1,
    output ledT        rgb2
);

    byteT fifoLevel;                            // bytes the card returned
    byteT bcc;
    byteT uidXor;
    logic otherStrobe;

    assign uidXor      = uid[31:24] ^ uid[23:16] ^ uid[15:8] ^ uid[7:0];
    assign otherStrobe = capLevel || capUid || capBcc || showLed || clearLed;

    always_ff @(posedge clk) begin
        if (capLevel) begin
            fifoLevel <= spiRxByte;
        end
        if (capBcc) begin
            bcc <= spiRxByte;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uid    <= '0;
            cardOk <= 1'b0;
            rgb1   <= LedOff;
            rgb2   <= LedOff;
        end else begin
            if (capUid) begin
                uid[{~uidByteSel, 3'b000} +: 8] <= spiRxByte; // byte 0 lands on top
            end
            if (checkFrame) begin
                cardOk <= (fifoLevel == UidFrameLen) && (bcc == uidXor);
            end else if (otherStrobe) begin
                cardOk <= 1'b0;                 // one step wide pulse
            end
            // led choice looks at the uid only, not at cardOk
            if (showLed) begin
                rgb1 <= (uid == UidKnownGood) ? LedWhite : LedOff;
                rgb2 <= (uid == UidKnownBad) ? LedWhite : LedOff;
            end else if (clearLed) begin
                rgb1 <= LedOff;
                rgb2 <= LedOff;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rc522Reader.sv */
`timescale 1ns/10ps
`default_nettype none

module rc522Reader import rfidPkg::*; #(
    parameter int stepBits = DefaultStepBits    // shortened in simulation
) (
    input  logic clk,
    input  logic rst_n,
    input  logic miso,
    output logic sclk,
    output logic mosi,
    output logic csN,
    output logic chipRst,
    output uidT  uid,
    output logic cardOk,
    output ledT  rgb1,                          // known good card
    output ledT  rgb2                           // known bad card
);

    logic       stepTick;
    logic       spiStart;
    logic       spiBusy;
    spiWordT    spiWord;
    byteT       spiRxByte;
    logic       capLevel;
    logic       capUid;
    logic [1:0] uidByteSel;
    logic       capBcc;
    logic       checkFrame;
    logic       showLed;
    logic       clearLed;

    stepTimer #(
        .stepBits(stepBits)
    ) stepTimer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .stepTick(stepTick)
    );

    readerSequencer readerSequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stepTick  (stepTick),
        .spiBusy   (spiBusy),
        .spiRxByte (spiRxByte),
        .spiStart  (spiStart),
        .spiWord   (spiWord),
        .chipRst   (chipRst),
        .capLevel  (capLevel),
        .capUid    (capUid),
        .uidByteSel(uidByteSel),
        .capBcc    (capBcc),
        .checkFrame(checkFrame),
        .showLed   (showLed),
        .clearLed  (clearLed)
    );

    spiMaster spiMaster_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .spiStart (spiStart),
        .spiWord  (spiWord),
        .miso     (miso),
        .spiBusy  (spiBusy),
        .sclk     (sclk),
        .mosi     (mosi),
        .csN      (csN),
        .spiRxByte(spiRxByte)
    );

    cardCheck cardCheck_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .spiRxByte (spiRxByte),
        .capLevel  (capLevel),
        .capUid    (capUid),
        .uidByteSel(uidByteSel),
        .capBcc    (capBcc),
        .checkFrame(checkFrame),
        .showLed   (showLed),
        .clearLed  (clearLed),
        .uid       (uid),
        .cardOk    (cardOk),
        .rgb1      (rgb1),
        .rgb2      (rgb2)
    );

endmodule

`default_nettype wire

/* hw/readerSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module readerSequencer import rfidPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stepTick,
    input  logic       spiBusy,
    input  byteT       spiRxByte,
    output logic       spiStart,
    output spiWordT    spiWord,
    output logic       chipRst,                 // chip NRSTPD pin held low resets the chip
    output logic       capLevel,
    output logic       capUid,
    output logic [1:0] uidByteSel,
    output logic       capBcc,
    output logic       checkFrame,
    output logic       showLed,
    output logic       clearLed
);

    stepT     step;
    stepT     uidOffset;                        // distance from the first uid capture
    seqStateT phase;
    logic [2:0] pollCnt;                        // misses since the last REQA
    logic     newCard;                          // RxIRq seen on the last poll
    logic     advance;
    logic     nextGo;
    spiWordT  nextWord;

    function automatic spiWordT wrFrame(regAddrT addr, byteT data);
        return {addr, data};
    endfunction

    function automatic spiWordT rdFrame(regAddrT addr);
        return {addr | ReadFlag, 8'h00};
    endfunction

    assign advance   = stepTick && !spiBusy;    // a tick during a frame is lost
    assign uidOffset = step - 10'd86;

    always_comb begin
        if (step < 10'd3) phase = SeqChipRst;
        else if (step < 10'd50) phase = SeqWaitChip;
        else if (step < ReqaStep) phase = SeqInit;
        else if (step < PollStep) phase = SeqReqa;
        else if (step < 10'd73) phase = SeqPoll;
        else if (step < 10'd83) phase = SeqSelect;
        else if (step < 10'd96) phase = SeqRead;
        else if (step < LedOnStep) phase = SeqCheck;
        else phase = SeqShow;
    end

    // frame issued on each step that has one
    always_comb begin
        nextGo   = 1'b1;
        nextWord = rdFrame(FIFODataReg);
        case (step)
            10'd50: nextWord = wrFrame(TxModeReg, 8'h00);       // 106 kBd transmit
            10'd51: nextWord = wrFrame(RxModeReg, 8'h00);       // 106 kBd receive
            10'd52: nextWord = wrFrame(ModWidthReg, 8'h26);
            10'd53: nextWord = wrFrame(TModeReg, 8'h80);        // timer auto start
            10'd54: nextWord = wrFrame(TPrescalerReg, 8'hA9);
            10'd55: nextWord = wrFrame(TReloadRegH, 8'h03);     // 25 ms timeout
            10'd56: nextWord = wrFrame(TReloadRegL, 8'hE8);
            10'd57: nextWord = wrFrame(TxASKReg, 8'h40);        // force 100% ASK
            10'd58: nextWord = wrFrame(ModeReg, 8'h3D);         // crc preset 6363
            10'd59: nextWord = rdFrame(TxControlReg);
            10'd60: nextWord = wrFrame(TxControlReg, spiRxByte | AntennaOn);
            10'd62: nextWord = wrFrame(CommandReg, PcdIdle);
            10'd63: nextWord = wrFrame(ComIrqReg, 8'h7F);       // clear irq bits
            10'd64: nextWord = wrFrame(FIFOLevelReg, 8'h80);    // flush fifo
            10'd65: nextWord = wrFrame(FIFODataReg, PiccReqa);
            10'd66: nextWord = wrFrame(BitFramingReg, 8'h07);   // 7-bit frame
            10'd67: nextWord = wrFrame(CommandReg, PcdTransceive);
            10'd68: nextWord = wrFrame(BitFramingReg, 8'h87);   // StartSend
            10'd70: nextWord = rdFrame(ComIrqReg);
            10'd73: nextWord = wrFrame(FIFOLevelReg, 8'h80);
            10'd74: nextWord = wrFrame(FIFODataReg, PiccSelCl1);
            10'd75: nextWord = wrFrame(FIFODataReg, 8'h20);     // NVB with no uid bits known
            10'd76: nextWord = wrFrame(BitFramingReg, 8'h00);
            10'd77: nextWord = wrFrame(CommandReg, PcdTransceive);
            10'd78: nextWord = wrFrame(BitFramingReg, 8'h80);
            10'd83: nextWord = rdFrame(FIFOLevelReg);
            10'd85, 10'd87, 10'd89, 10'd91, 10'd93: begin
                nextWord = rdFrame(FIFODataReg);                // uid0..3 then bcc
            end
            default: nextGo = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (advance && nextGo) begin
            spiWord <= nextWord;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= '0;
            pollCnt    <= '0;
            newCard    <= 1'b0;
            chipRst    <= 1'b1;
            spiStart   <= 1'b0;
            capLevel   <= 1'b0;
            capUid     <= 1'b0;
            uidByteSel <= '0;
            capBcc     <= 1'b0;
            checkFrame <= 1'b0;
            showLed    <= 1'b0;
            clearLed   <= 1'b0;
        end else begin
            spiStart   <= 1'b0;                 // strobes last one clock
            capLevel   <= 1'b0;
            capUid     <= 1'b0;
            capBcc     <= 1'b0;
            checkFrame <= 1'b0;
            showLed    <= 1'b0;
            clearLed   <= 1'b0;
            if (advance) begin
                spiStart <= nextGo;
                if (phase == SeqChipRst) begin
                    chipRst <= (step != 10'd1); // low for step 1 only
                end
                if (step == 10'd71) begin
                    newCard <= spiRxByte[RxIrqBit];
                end
                // captures run on the step after each read
                if (phase == SeqRead && !step[0]) begin
                    capLevel <= (step == 10'd84);
                    capBcc   <= (step == 10'd94);
                    if (step >= 10'd86 && step <= 10'd92) begin
                        capUid     <= 1'b1;
                        uidByteSel <= uidOffset[2:1];
                    end
                end
                checkFrame <= (step == 10'd96);
                showLed    <= (step == LedOnStep);
                clearLed   <= (step == 10'd97) || (step == LedOffStep); // 97 ends cardOk

                if (phase == SeqPoll && step == 10'd72 && !newCard) begin
                    if (pollCnt == 3'(PollRetries - 1)) begin
                        pollCnt <= '0;
                        step    <= ReqaStep;    // give up and restart at REQA
                    end else begin
                        pollCnt <= pollCnt + 1'b1;
                        step    <= PollStep;
                    end
                end else if (step == LedOffStep + 10'd1) begin
                    step <= ReqaStep;
                end else begin
                    if (step == 10'd72) begin
                        pollCnt <= '0;          // card answered
                    end
                    step <= step + 10'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rfidPkg.sv */
`default_nettype none

package rfidPkg;

    typedef logic [7:0]  byteT;                  // register value or spi data byte
    typedef logic [7:0]  regAddrT;               // address already shifted left by one
    typedef logic [15:0] spiWordT;               // address byte then data byte
    typedef logic [31:0] uidT;                   // byte 0 sits in the top byte
    typedef logic [9:0]  stepT;                  // schedule step number
    typedef logic [2:0]  ledT;                   // blue, green, red

    typedef enum logic [3:0] {
        SeqChipRst,                              // hard reset pulse on the chip
        SeqWaitChip,                             // chip oscillator start-up
        SeqInit,                                 // register setup and antenna on
        SeqReqa,                                 // REQA transceive
        SeqPoll,                                 // ComIrqReg polling
        SeqSelect,                               // SELECT cascade level 1
        SeqRead,                                 // fifo level, uid and bcc reads
        SeqCheck,                                // frame check, cardOk pulse
        SeqShow                                  // leds lit until the hold runs out
    } seqStateT;

    localparam regAddrT CommandReg    = 8'h01 << 1;
    localparam regAddrT ComIrqReg     = 8'h04 << 1;
    localparam regAddrT FIFODataReg   = 8'h09 << 1;
    localparam regAddrT FIFOLevelReg  = 8'h0A << 1;
    localparam regAddrT BitFramingReg = 8'h0D << 1;
    localparam regAddrT ModeReg       = 8'h11 << 1;
    localparam regAddrT TxModeReg     = 8'h12 << 1;
    localparam regAddrT RxModeReg     = 8'h13 << 1;
    localparam regAddrT TxControlReg  = 8'h14 << 1;
    localparam regAddrT TxASKReg      = 8'h15 << 1;
    localparam regAddrT ModWidthReg   = 8'h24 << 1;
    localparam regAddrT TModeReg      = 8'h2A << 1;
    localparam regAddrT TPrescalerReg = 8'h2B << 1;
    localparam regAddrT TReloadRegH   = 8'h2C << 1;
    localparam regAddrT TReloadRegL   = 8'h2D << 1;

    localparam byteT PcdIdle       = 8'h00;      // cancel running command
    localparam byteT PcdTransceive = 8'h0C;      // send fifo, then receive
    localparam byteT PiccReqa      = 8'h26;      // 7-bit request frame
    localparam byteT PiccSelCl1    = 8'h93;      // anticollision/select, level 1

    localparam byteT ReadFlag    = 8'h80;        // msb of the address byte marks a read
    localparam byteT AntennaOn   = 8'h03;        // Tx1RFEn and Tx2RFEn
    localparam int   RxIrqBit    = 5;            // ComIrqReg bit set when a card answered
    localparam byteT UidFrameLen = 8'd5;         // four uid bytes plus bcc

    localparam int SclkDivBits     = 4;          // 16 clocks per sclk half period
    localparam int DefaultStepBits = 17;         // 2^17 clocks per step on silicon
    localparam int PollRetries     = 6;

    localparam stepT ReqaStep     = 10'd62;
    localparam stepT PollStep     = 10'd70;
    localparam stepT LedOnStep    = 10'd98;
    localparam stepT LedHoldSteps = 10'd402;
    localparam stepT LedOffStep   = LedOnStep + LedHoldSteps;

    localparam uidT UidKnownGood = 32'h2359A629; // lights rgb1
    localparam uidT UidKnownBad  = 32'hF3F3A414; // lights rgb2
    localparam ledT LedOff       = 3'b000;
    localparam ledT LedWhite     = 3'b111;

endpackage

`default_nettype wire

/* hw/spiMaster.sv */
`timescale 1ns/10ps
`default_nettype none

module spiMaster import rfidPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    spiStart,                   // one-cycle strobe, word latched here
    input  spiWordT spiWord,
    input  logic    miso,
    output logic    spiBusy,
    output logic    sclk,                       // mode 0, idles low
    output logic    mosi,
    output logic    csN,
    output byteT    spiRxByte                   // last eight bits shifted in
);

    logic [SclkDivBits:0] divCnt;               // one full sclk period per bit
    logic [3:0]           bitCnt;
    spiWordT              txShift;
    byteT                 rxShift;
    logic                 launch;
    logic                 halfDone;
    logic                 riseEdge;
    logic                 fallEdge;

    assign launch    = spiStart && !spiBusy;
    assign halfDone  = &divCnt[SclkDivBits-1:0];
    assign riseEdge  = spiBusy && halfDone && !divCnt[SclkDivBits]; // end of low half
    assign fallEdge  = spiBusy && halfDone && divCnt[SclkDivBits];  // end of the bit
    assign spiRxByte = rxShift;

    // shift registers
    always_ff @(posedge clk) begin
        if (launch) begin
            txShift <= spiWord;
        end else if (fallEdge) begin
            txShift <= {txShift[14:0], 1'b0};   // next bit onto mosi
        end
        if (riseEdge) begin
            rxShift <= {rxShift[6:0], miso};    // msb first
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spiBusy <= 1'b0;
            csN     <= 1'b1;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            divCnt  <= '0;
            bitCnt  <= '0;
        end else if (launch) begin
            spiBusy <= 1'b1;
            csN     <= 1'b0;                    // one clock after the strobe
            mosi    <= spiWord[15];             // first bit set up before first rise
            divCnt  <= '0;
            bitCnt  <= '0;
        end else if (spiBusy) begin
            divCnt <= divCnt + 1'b1;
            if (riseEdge) begin
                sclk <= 1'b1;
            end
            if (fallEdge) begin
                sclk   <= 1'b0;
                mosi   <= txShift[14];          // zero once the word is out
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == 4'd15) begin      // 16th bit done, 512 clocks in
                    spiBusy <= 1'b0;
                    csN     <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/stepTimer.sv */
`timescale 1ns/10ps
`default_nettype none

module stepTimer import rfidPkg::*; #(
    parameter int stepBits = DefaultStepBits    // log2 of the step length in clocks
) (
    input  logic clk,
    input  logic rst_n,
    output logic stepTick                       // one clock wide, once per step
);

    logic [stepBits-1:0] prescale;              // free running, never cleared by control

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
            stepTick <= 1'b0;
        end else begin
            prescale <= prescale + 1'b1;
            stepTick <= &prescale;              // all ones, wraps next clock
        end
    end

endmodule

`default_nettype wire

/* rc522Reader.f */
hw/rfidPkg.sv
hw/stepTimer.sv
hw/spiMaster.sv
hw/readerSequencer.sv
hw/cardCheck.sv
hw/rc522Reader.sv
bench/rc522CardModel.sv
bench/rc522Reader_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rc522Reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module rc522Reader_tb \
    -f rc522Reader.f -o rc522Reader_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/rc522Reader_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
